//--- all.f
ssr_cfg_pkg.sv
ssr_data_pkg.sv
ssr_switch.sv
ssr_cfg_regs.sv
ssr_fifo.sv
ssr_lane.sv
ssr_top.sv
tb_ssr.sv

//--- run.sh
#!/bin/sh
# build and run the ssr testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_ssr -f all.f -o Vtb_ssr

output=$(./obj_dir/Vtb_ssr)
echo "$output"

if echo "$output" | grep -qx "TEST PASSED"; then
  exit 0
fi
exit 1

//--- ssr_cfg_pkg.sv
`default_nettype none

// register map and configuration address layout of the ssr subsystem
package ssr_cfg_pkg;

  // number of data mover lanes
  localparam int unsigned NumLanes = 2;

  // core register number, same width as an fp register index
  typedef logic [4:0] reg_num_t;

  // core register owned by each lane
  localparam reg_num_t ssr_regs [NumLanes] = '{5'd0, 5'd1};

  // configuration address, bit 3 picks the lane, bits 2:0 the register
  typedef logic [3:0] cfg_addr_t;

  // register offsets inside one lane
  localparam logic [2:0] CfgBase   = 3'd0;
  localparam logic [2:0] CfgStride = 3'd1;
  localparam logic [2:0] CfgCount  = 3'd2;
  // 1 selects a write stream
  localparam logic [2:0] CfgMode   = 3'd3;
  // write launches the stream, read returns busy
  localparam logic [2:0] CfgStart  = 3'd4;

endpackage

`default_nettype wire

//--- ssr_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module ssr_cfg_regs
  import ssr_cfg_pkg::*;
  import ssr_data_pkg::*;
#(
  parameter int unsigned CountWidth = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // register port
  input  logic                  cfg_we_i,
  input  cfg_addr_t             cfg_addr_i,
  input  addr_t                 cfg_wdata_i,
  output addr_t                 cfg_rdata_o,
  // lane status
  input  logic                  busy_i       [NumLanes],
  // lane settings
  output addr_t                 base_o       [NumLanes],
  output addr_t                 stride_o     [NumLanes],
  output logic [CountWidth-1:0] count_o      [NumLanes],
  output logic                  write_mode_o [NumLanes],
  output logic                  start_o      [NumLanes]
);

  logic       lane_sel;
  logic [2:0] offset;
  // busy as seen by software, covers the start cycle too
  logic       lane_busy [NumLanes];

  assign lane_sel = cfg_addr_i[3];
  assign offset   = cfg_addr_i[2:0];

  always_comb begin
    for (int l = 0; l < NumLanes; l++) begin
      lane_busy[l] = busy_i[l] | start_o[l];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int l = 0; l < NumLanes; l++) begin
        base_o[l]       <= '0;
        stride_o[l]     <= '0;
        count_o[l]      <= '0;
        write_mode_o[l] <= 1'b0;
        start_o[l]      <= 1'b0;
      end
    end else begin
      // start is a single cycle pulse
      for (int l = 0; l < NumLanes; l++) begin
        start_o[l] <= 1'b0;
      end
      if (cfg_we_i) begin
        case (offset)
          CfgBase:   base_o[lane_sel]       <= cfg_wdata_i;
          CfgStride: stride_o[lane_sel]     <= cfg_wdata_i;
          CfgCount:  count_o[lane_sel]      <= cfg_wdata_i[CountWidth-1:0];
          CfgMode:   write_mode_o[lane_sel] <= cfg_wdata_i[0];
          // dropped while the lane still runs
          CfgStart:  start_o[lane_sel]      <= ~lane_busy[lane_sel];
          default: ;
        endcase
      end
    end
  end

  // readback, unused offsets read zero
  always_comb begin
    cfg_rdata_o = '0;
    case (offset)
      CfgBase:   cfg_rdata_o = base_o[lane_sel];
      CfgStride: cfg_rdata_o = stride_o[lane_sel];
      CfgCount:  cfg_rdata_o = addr_t'(count_o[lane_sel]);
      CfgMode:   cfg_rdata_o = addr_t'(write_mode_o[lane_sel]);
      CfgStart:  cfg_rdata_o = addr_t'(lane_busy[lane_sel]);
      default:   cfg_rdata_o = '0;
    endcase
  end

  // a lane must never be restarted in the middle of a stream
  for (genvar l = 0; l < NumLanes; l++) begin : g_start_chk
    a_no_restart: assert property (
      @(posedge clk_i) disable iff (reset_i) start_o[l] |-> !busy_i[l])
      else $error("ssr_cfg_regs: start on busy lane %0d", l);
  end

endmodule

`default_nettype wire

//--- ssr_data_pkg.sv
`default_nettype none

// data path widths and payload types
package ssr_data_pkg;

  localparam int unsigned DataWidth = 64;
  localparam int unsigned AddrWidth = 32;

  // one fp data word
  typedef logic [DataWidth-1:0] data_t;
  // byte address into lane memory
  typedef logic [AddrWidth-1:0] addr_t;

  // write beat on its way to memory
  typedef struct packed {
    addr_t addr;
    data_t data;
  } wr_beat_t;

endpackage

`default_nettype wire

//--- ssr_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module ssr_fifo #(
  parameter int unsigned FifoDepth = 4,
  parameter type payload_t = logic [63:0]
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             push_i,
  input  payload_t                         data_i,
  input  logic                             pop_i,
  output payload_t                         data_o,
  output logic                             full_o,
  output logic                             empty_o,
  output logic [$clog2(FifoDepth+1)-1:0]   fill_o
);

  localparam int unsigned ptr_w  = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int unsigned fill_w = $clog2(FifoDepth + 1);

  payload_t           mem_q [FifoDepth];
  logic [ptr_w-1:0]   wr_ptr_q;
  logic [ptr_w-1:0]   rd_ptr_q;
  logic [fill_w-1:0]  fill_q;

  // pointer step with wrap, depth need not be a power of two
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // count only moves when exactly one side acts
      if (push_i && !pop_i) begin
        fill_q <= fill_q + 1'b1;
      end else if (pop_i && !push_i) begin
        fill_q <= fill_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  assign data_o  = mem_q[rd_ptr_q];
  assign fill_o  = fill_q;
  assign full_o  = (fill_q == fill_w'(FifoDepth));
  assign empty_o = (fill_q == '0);

  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (reset_i) push_i |-> !full_o)
    else $error("ssr_fifo: push while full");

  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (reset_i) pop_i |-> !empty_o)
    else $error("ssr_fifo: pop while empty");

endmodule

`default_nettype wire

//--- ssr_lane.sv
`timescale 1ns/1ps
`default_nettype none

module ssr_lane
  import ssr_data_pkg::*;
#(
  parameter int unsigned FifoDepth  = 4,
  parameter int unsigned CountWidth = 16
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // settings from the configuration block
  input  addr_t                 base_i,
  input  addr_t                 stride_i,
  input  logic [CountWidth-1:0] count_i,
  input  logic                  write_mode_i,
  input  logic                  start_i,
  // switch side
  input  logic                  lane_ready_i,
  input  logic                  lane_write_i,
  input  data_t                 lane_wdata_i,
  output logic                  lane_valid_o,
  output data_t                 lane_rdata_o,
  output logic                  busy_o,
  // memory side
  output logic                  mem_req_o,
  output logic                  mem_we_o,
  output addr_t                 mem_addr_o,
  output data_t                 mem_wdata_o,
  input  logic                  mem_gnt_i,
  input  logic                  mem_rvalid_i,
  input  data_t                 mem_rdata_i
);

  localparam int unsigned cnt_w = $clog2(FifoDepth + 1);

  // control state
  logic                  busy_q;
  logic                  mode_q;
  logic [CountWidth-1:0] req_left_q;
  logic [CountWidth-1:0] beat_left_q;
  logic [cnt_w-1:0]      outstanding_q;
  // address walk
  addr_t                 addr_q;
  addr_t                 stride_q;

  logic [cnt_w-1:0]      rd_fill;
  logic [cnt_w:0]        rd_in_use;
  logic                  rd_empty;
  logic                  rd_credit;
  logic                  rd_req;
  logic                  rd_fire;
  logic                  rd_pop;
  logic                  wr_full;
  logic                  wr_empty;
  logic                  wr_req;
  logic                  wr_fire;
  logic                  wr_push;
  wr_beat_t              wr_beat;
  wr_beat_t              wr_head;

  // words in flight plus words held must stay below depth
  assign rd_in_use = {1'b0, outstanding_q} + {1'b0, rd_fill};
  assign rd_credit = rd_in_use < (cnt_w + 1)'(FifoDepth);
  assign rd_req    = busy_q && !mode_q && (req_left_q != '0) && rd_credit;
  assign rd_fire   = rd_req && mem_gnt_i;
  // core consumes a prefetched word
  assign rd_pop    = busy_q && !mode_q && lane_ready_i && !lane_write_i;

  // core hands over a beat, paired with the next address
  assign wr_push   = busy_q && mode_q && lane_ready_i && lane_write_i;
  assign wr_req    = busy_q && mode_q && !wr_empty;
  assign wr_fire   = wr_req && mem_gnt_i;
  assign wr_beat   = '{addr: addr_q, data: lane_wdata_i};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q        <= 1'b0;
      mode_q        <= 1'b0;
      req_left_q    <= '0;
      beat_left_q   <= '0;
      outstanding_q <= '0;
    end else begin
      // zero length streams never go busy
      if (start_i && !busy_q && (count_i != '0)) begin
        busy_q      <= 1'b1;
        mode_q      <= write_mode_i;
        req_left_q  <= count_i;
        beat_left_q <= count_i;
      end else if (busy_q) begin
        if (rd_fire || wr_push) begin
          req_left_q <= req_left_q - 1'b1;
        end
        // a beat is done once consumed (read) or granted (write)
        if (rd_pop || wr_fire) begin
          beat_left_q <= beat_left_q - 1'b1;
          if (beat_left_q == CountWidth'(1)) begin
            busy_q <= 1'b0;
          end
        end
      end
      // reads in flight
      if (rd_fire && !mem_rvalid_i) begin
        outstanding_q <= outstanding_q + 1'b1;
      end else if (mem_rvalid_i && !rd_fire) begin
        outstanding_q <= outstanding_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i && !busy_q) begin
      addr_q   <= base_i;
      stride_q <= stride_i;
    end else if (rd_fire || wr_push) begin
      addr_q <= addr_q + stride_q;
    end
  end

  // prefetched read words
  ssr_fifo #(
    .FifoDepth (FifoDepth),
    .payload_t (data_t)
  ) i_rd_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (mem_rvalid_i),
    .data_i  (mem_rdata_i),
    .pop_i   (rd_pop),
    .data_o  (lane_rdata_o),
    .full_o  (),
    .empty_o (rd_empty),
    .fill_o  (rd_fill)
  );

  // address and data pairs waiting for a grant
  ssr_fifo #(
    .FifoDepth (FifoDepth),
    .payload_t (wr_beat_t)
  ) i_wr_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .push_i  (wr_push),
    .data_i  (wr_beat),
    .pop_i   (wr_fire),
    .data_o  (wr_head),
    .full_o  (wr_full),
    .empty_o (wr_empty),
    .fill_o  ()
  );

  // write mode: room for a beat and beats still to accept
  assign lane_valid_o = mode_q ? (busy_q && (req_left_q != '0) && !wr_full) : !rd_empty;
  assign busy_o       = busy_q;
  assign mem_req_o    = rd_req || wr_req;
  assign mem_we_o     = busy_q && mode_q;
  assign mem_addr_o   = mode_q ? wr_head.addr : addr_q;
  assign mem_wdata_o  = wr_head.data;

  // read data only comes back for a granted request
  a_rvalid_credit: assert property (
    @(posedge clk_i) disable iff (reset_i) mem_rvalid_i |-> (outstanding_q != '0))
    else $error("ssr_lane: read data without outstanding request");

  // the port the core uses has to match the programmed direction
  a_dir_match: assert property (
    @(posedge clk_i) disable iff (reset_i) lane_ready_i |-> (lane_write_i == write_mode_i))
    else $error("ssr_lane: access direction differs from lane mode");

endmodule

`default_nettype wire

//--- ssr_switch.sv
`timescale 1ns/1ps
`default_nettype none

module ssr_switch
  import ssr_cfg_pkg::*;
  import ssr_data_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  // core read ports
  input  reg_num_t ssr_raddr_i  [3],
  output data_t    ssr_rdata_o  [3],
  input  logic     ssr_rvalid_i [3],
  output logic     ssr_rready_o [3],
  input  logic     ssr_rdone_i  [3],
  // core write port
  input  reg_num_t ssr_waddr_i,
  input  data_t    ssr_wdata_i,
  input  logic     ssr_wvalid_i,
  output logic     ssr_wready_o,
  input  logic     ssr_wdone_i,
  // lane side
  input  data_t    lane_rdata_i [NumLanes],
  output data_t    lane_wdata_o [NumLanes],
  output logic     lane_write_o [NumLanes],
  input  logic     lane_valid_i [NumLanes],
  output logic     lane_ready_o [NumLanes]
);

  localparam int unsigned num_rd = 3;
  localparam int unsigned num_in = num_rd + 1;

  // all core ports merged into one list, write port last
  reg_num_t port_addr  [num_in];
  data_t    port_wdata [num_in];
  logic     port_valid [num_in];
  logic     port_done  [num_in];
  logic     port_write [num_in];
  data_t    port_rdata [num_in];
  logic     port_ready [num_in];
  // port i addresses lane o
  logic [num_in-1:0] hit [NumLanes];

  always_comb begin
    for (int i = 0; i < num_rd; i++) begin
      port_addr[i]    = ssr_raddr_i[i];
      port_wdata[i]   = '0;
      port_valid[i]   = ssr_rvalid_i[i];
      port_done[i]    = ssr_rdone_i[i];
      port_write[i]   = 1'b0;
      ssr_rdata_o[i]  = port_rdata[i];
      ssr_rready_o[i] = port_ready[i];
    end
    port_addr[num_rd]  = ssr_waddr_i;
    port_wdata[num_rd] = ssr_wdata_i;
    port_valid[num_rd] = ssr_wvalid_i;
    port_done[num_rd]  = ssr_wdone_i;
    port_write[num_rd] = 1'b1;
    ssr_wready_o       = port_ready[num_rd];
  end

  // address compare against the fixed register map
  always_comb begin
    for (int o = 0; o < NumLanes; o++) begin
      for (int i = 0; i < num_in; i++) begin
        hit[o][i] = port_valid[i] && (port_addr[i] == ssr_regs[o]);
      end
    end
  end

  // crossbar, unmatched ports and idle lanes stay low
  always_comb begin
    for (int o = 0; o < NumLanes; o++) begin
      lane_ready_o[o] = 1'b0;
      lane_write_o[o] = 1'b0;
      lane_wdata_o[o] = '0;
    end
    for (int i = 0; i < num_in; i++) begin
      port_rdata[i] = '0;
      port_ready[i] = 1'b0;
    end
    for (int o = 0; o < NumLanes; o++) begin
      for (int i = 0; i < num_in; i++) begin
        if (hit[o][i]) begin
          lane_ready_o[o] = port_done[i];
          lane_write_o[o] = port_write[i];
          lane_wdata_o[o] = port_wdata[i];
          port_rdata[i]   = lane_rdata_i[o];
          port_ready[i]   = lane_valid_i[o];
        end
      end
    end
  end

  // the core must never aim two ports at the same lane
  for (genvar o = 0; o < NumLanes; o++) begin : g_lane_chk
    a_single_port: assert property (
      @(posedge clk_i) disable iff (reset_i) $onehot0(hit[o]))
      else $error("ssr_switch: several ports select lane %0d", o);
  end

endmodule

`default_nettype wire

//--- ssr_top.sv
`timescale 1ns/1ps
`default_nettype none

module ssr_top
  import ssr_cfg_pkg::*;
  import ssr_data_pkg::*;
#(
  parameter int unsigned FifoDepth  = 4,
  parameter int unsigned CountWidth = 16
) (
  input  logic      clk_i,
  input  logic      reset_i,
  // core read ports
  input  reg_num_t  ssr_raddr_i  [3],
  output data_t     ssr_rdata_o  [3],
  input  logic      ssr_rvalid_i [3],
  output logic      ssr_rready_o [3],
  input  logic      ssr_rdone_i  [3],
  // core write port
  input  reg_num_t  ssr_waddr_i,
  input  data_t     ssr_wdata_i,
  input  logic      ssr_wvalid_i,
  output logic      ssr_wready_o,
  input  logic      ssr_wdone_i,
  // configuration port
  input  logic      cfg_we_i,
  input  cfg_addr_t cfg_addr_i,
  input  addr_t     cfg_wdata_i,
  output addr_t     cfg_rdata_o,
  // one memory port per lane
  output logic      mem_req_o    [NumLanes],
  output logic      mem_we_o     [NumLanes],
  output addr_t     mem_addr_o   [NumLanes],
  output data_t     mem_wdata_o  [NumLanes],
  input  logic      mem_gnt_i    [NumLanes],
  input  logic      mem_rvalid_i [NumLanes],
  input  data_t     mem_rdata_i  [NumLanes]
);

  // switch to lane
  data_t                 lane_rdata [NumLanes];
  data_t                 lane_wdata [NumLanes];
  logic                  lane_write [NumLanes];
  logic                  lane_valid [NumLanes];
  logic                  lane_ready [NumLanes];
  // configuration to lane
  addr_t                 base       [NumLanes];
  addr_t                 stride     [NumLanes];
  logic [CountWidth-1:0] count      [NumLanes];
  logic                  write_mode [NumLanes];
  logic                  start      [NumLanes];
  logic                  busy       [NumLanes];

  ssr_switch i_switch (
    .clk_i, .reset_i,
    .ssr_raddr_i, .ssr_rdata_o, .ssr_rvalid_i, .ssr_rready_o, .ssr_rdone_i,
    .ssr_waddr_i, .ssr_wdata_i, .ssr_wvalid_i, .ssr_wready_o, .ssr_wdone_i,
    .lane_rdata_i (lane_rdata),
    .lane_wdata_o (lane_wdata),
    .lane_write_o (lane_write),
    .lane_valid_i (lane_valid),
    .lane_ready_o (lane_ready)
  );

  ssr_cfg_regs #(.CountWidth(CountWidth)) i_cfg_regs (
    .clk_i, .reset_i, .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
    .busy_i       (busy),
    .base_o       (base),
    .stride_o     (stride),
    .count_o      (count),
    .write_mode_o (write_mode),
    .start_o      (start)
  );

  for (genvar l = 0; l < NumLanes; l++) begin : g_lane
    ssr_lane #(.FifoDepth(FifoDepth), .CountWidth(CountWidth)) i_lane (
      .clk_i, .reset_i,
      .base_i       (base[l]),
      .stride_i     (stride[l]),
      .count_i      (count[l]),
      .write_mode_i (write_mode[l]),
      .start_i      (start[l]),
      .lane_ready_i (lane_ready[l]),
      .lane_write_i (lane_write[l]),
      .lane_wdata_i (lane_wdata[l]),
      .lane_valid_o (lane_valid[l]),
      .lane_rdata_o (lane_rdata[l]),
      .busy_o       (busy[l]),
      .mem_req_o    (mem_req_o[l]),
      .mem_we_o     (mem_we_o[l]),
      .mem_addr_o   (mem_addr_o[l]),
      .mem_wdata_o  (mem_wdata_o[l]),
      .mem_gnt_i    (mem_gnt_i[l]),
      .mem_rvalid_i (mem_rvalid_i[l]),
      .mem_rdata_i  (mem_rdata_i[l])
    );
  end

endmodule

`default_nettype wire

//--- tb_ssr.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ssr
  import ssr_cfg_pkg::*;
  import ssr_data_pkg::*;
();

  localparam int unsigned FifoDepth   = 4;
  localparam int unsigned CountWidth  = 16;
  localparam int          Timeout     = 2000;
  localparam int          WatchCycles = 300;
  localparam int          MemWords    = 256;
  localparam int          NumRows     = 6;
  localparam int          NumGroups   = 5;
  localparam int          WritePort   = 3;
  localparam logic [31:0] Seed        = 32'had58_d014;

  // one stream per row
  // rows of one group run at the same time
  typedef struct {
    int    grp;
    int    lane;
    int    port;
    int    reg_num;
    addr_t base;
    addr_t stride;
    int    count;
    bit    write;
    int    gnt_pct;
    int    max_delay;
    bit    restart;
  } row_t;

  logic      clk_i = 1'b0;
  logic      reset_i;
  reg_num_t  ssr_raddr_i  [3];
  data_t     ssr_rdata_o  [3];
  logic      ssr_rvalid_i [3];
  logic      ssr_rready_o [3];
  logic      ssr_rdone_i  [3];
  reg_num_t  ssr_waddr_i;
  data_t     ssr_wdata_i;
  logic      ssr_wvalid_i;
  logic      ssr_wready_o;
  logic      ssr_wdone_i;
  logic      cfg_we_i;
  cfg_addr_t cfg_addr_i;
  addr_t     cfg_wdata_i;
  addr_t     cfg_rdata_o;
  logic      mem_req_o    [NumLanes];
  logic      mem_we_o     [NumLanes];
  addr_t     mem_addr_o   [NumLanes];
  data_t     mem_wdata_o  [NumLanes];
  logic      mem_gnt_i    [NumLanes] = '{default: 1'b0};
  logic      mem_rvalid_i [NumLanes] = '{default: 1'b0};
  data_t     mem_rdata_i  [NumLanes] = '{default: '0};

  // memory model state with one word array per lane
  data_t       mem_q [NumLanes][MemWords];
  int          gnt_pct [NumLanes];
  logic [31:0] mem_rng = Seed;
  logic [31:0] core_rng [4];

  row_t  rows [NumRows];
  string names [NumGroups];
  int    errors = 0;
  int    tests_run = 0;
  int    tests_failed = 0;

  always #4 clk_i = ~clk_i;

  ssr_top #(
    .FifoDepth  (FifoDepth),
    .CountWidth (CountWidth)
  ) dut (
    .clk_i, .reset_i,
    .ssr_raddr_i, .ssr_rdata_o, .ssr_rvalid_i, .ssr_rready_o, .ssr_rdone_i,
    .ssr_waddr_i, .ssr_wdata_i, .ssr_wvalid_i, .ssr_wready_o, .ssr_wdone_i,
    .cfg_we_i, .cfg_addr_i, .cfg_wdata_i, .cfg_rdata_o,
    .mem_req_o, .mem_we_o, .mem_addr_o, .mem_wdata_o,
    .mem_gnt_i, .mem_rvalid_i, .mem_rdata_i
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // odd multiplier keeps the fill distinct for every address
  function automatic data_t pattern(input addr_t a);
    return data_t'(a) * 64'h9E37_79B9_7F4A_7C15;
  endfunction

  // words the core writes are tagged by row and beat
  function automatic data_t write_word(input int r, input int n);
    return 64'hA5A5_0000_0000_0000 | (data_t'(r) << 16) | data_t'(n);
  endfunction

  function automatic cfg_addr_t cfg_at(input int lane, input logic [2:0] off);
    return {lane[0], off};
  endfunction

  // lane l owns core register l
  function automatic bit mapped(input int reg_num);
    return reg_num >= 0 && reg_num < NumLanes;
  endfunction

  function automatic int next_delay(input int p, input int max_delay);
    core_rng[p] = lcg_next(core_rng[p]);
    return int'(core_rng[p][23:16]) % (max_delay + 1);
  endfunction

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input bit exp, input logic act);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      errors++;
    end
  endtask

  // grant comes from the lcg and read data follows an accepted read by one cycle
  always @(posedge clk_i) begin : mem_model
    addr_t a;
    for (int l = 0; l < NumLanes; l++) begin
      a = mem_addr_o[l];
      mem_rvalid_i[l] <= 1'b0;
      if (reset_i) begin
        mem_gnt_i[l] <= 1'b0;
      end else begin
        if (mem_req_o[l] && mem_gnt_i[l]) begin
          if (a >= addr_t'(MemWords * 8) || a[2:0] != 3'd0) begin
            $display("lane %0d accessed address %h outside the modeled memory", l, a);
            errors++;
          end else if (mem_we_o[l]) begin
            mem_q[l][a[10:3]] = mem_wdata_o[l];
          end else begin
            mem_rvalid_i[l] <= 1'b1;
            mem_rdata_i[l]  <= mem_q[l][a[10:3]];
          end
        end
        mem_rng = lcg_next(mem_rng);
        mem_gnt_i[l] <= (int'(mem_rng[30:16]) % 100) < gnt_pct[l];
      end
    end
  end

  task automatic fill_memory();
    for (int l = 0; l < NumLanes; l++) begin
      for (int w = 0; w < MemWords; w++) begin
        mem_q[l][w] = pattern(addr_t'(w) << 3);
      end
    end
  endtask

  task automatic cfg_write(input cfg_addr_t a, input addr_t d);
    @(posedge clk_i);
    cfg_we_i    <= 1'b1;
    cfg_addr_i  <= a;
    cfg_wdata_i <= d;
    @(posedge clk_i);
    cfg_we_i <= 1'b0;
  endtask

  // readback is combinational and sampled mid cycle
  task automatic cfg_read(input cfg_addr_t a, output addr_t d);
    @(posedge clk_i);
    cfg_addr_i <= a;
    @(negedge clk_i);
    d = cfg_rdata_o;
  endtask

  task automatic wait_rready(input int p, output bit ok);
    int cyc;
    ok = 1'b0;
    cyc = 0;
    while (!ok && cyc < Timeout) begin
      @(negedge clk_i);
      ok = ssr_rready_o[p];
      cyc++;
    end
    if (!ok) begin
      $display("timeout: read port %0d never offered a word", p);
      errors++;
    end
  endtask

  task automatic wait_wready(output bit ok);
    int cyc;
    ok = 1'b0;
    cyc = 0;
    while (!ok && cyc < Timeout) begin
      @(negedge clk_i);
      ok = ssr_wready_o;
      cyc++;
    end
    if (!ok) begin
      $display("timeout: write port never accepted a beat");
      errors++;
    end
  endtask

  task automatic wait_idle(input int lane, output bit ok);
    addr_t word;
    int    cyc;
    ok = 1'b0;
    cyc = 0;
    while (!ok && cyc < Timeout) begin
      cfg_read(cfg_at(lane, CfgStart), word);
      ok = (word[0] == 1'b0);
      cyc++;
    end
    if (!ok) begin
      $display("timeout: lane %0d stayed busy", lane);
      errors++;
    end
  endtask

  // every register reads back what was written
  // lanes get different values and all are written before the first read
  task automatic config_readback();
    addr_t word;
    for (int l = 0; l < NumLanes; l++) begin
      cfg_write(cfg_at(l, CfgBase), 32'hCAFE_0010 ^ addr_t'(l));
      cfg_write(cfg_at(l, CfgStride), 32'h0000_0018 + addr_t'(l));
      cfg_write(cfg_at(l, CfgCount), 32'h0000_002A + addr_t'(l));
      cfg_write(cfg_at(l, CfgMode), addr_t'(l));
    end
    for (int l = 0; l < NumLanes; l++) begin
      cfg_read(cfg_at(l, CfgBase), word);
      check_addr($sformatf("cfg_rdata_o lane %0d base", l), 32'hCAFE_0010 ^ addr_t'(l), word);
      cfg_read(cfg_at(l, CfgStride), word);
      check_addr($sformatf("cfg_rdata_o lane %0d stride", l), 32'h0000_0018 + addr_t'(l),
                 word);
      cfg_read(cfg_at(l, CfgCount), word);
      check_addr($sformatf("cfg_rdata_o lane %0d count", l), 32'h0000_002A + addr_t'(l),
                 word);
      cfg_read(cfg_at(l, CfgMode), word);
      check_addr($sformatf("cfg_rdata_o lane %0d mode", l), addr_t'(l), word);
      cfg_read(cfg_at(l, CfgStart), word);
      check_flag($sformatf("cfg_rdata_o lane %0d busy while idle", l), 1'b0, word[0]);
    end
  endtask

  task automatic start_row(input int r);
    addr_t word;
    int    lane;
    if (r < 0 || !mapped(rows[r].reg_num)) begin
      return;
    end
    lane = rows[r].lane;
    gnt_pct[lane] = rows[r].gnt_pct;
    cfg_write(cfg_at(lane, CfgBase), rows[r].base);
    cfg_write(cfg_at(lane, CfgStride), rows[r].stride);
    cfg_write(cfg_at(lane, CfgCount), addr_t'(rows[r].count));
    cfg_write(cfg_at(lane, CfgMode), addr_t'(rows[r].write));
    cfg_write(cfg_at(lane, CfgStart), 32'd1);
    cfg_read(cfg_at(lane, CfgStart), word);
    check_flag($sformatf("cfg_rdata_o lane %0d busy after start", lane), 1'b1, word[0]);
  endtask

  // core side of a read stream
  // word n comes from base + n * stride
  task automatic run_read(input int r);
    int    p;
    int    n;
    bit    ok;
    addr_t a;
    addr_t word;
    p = rows[r].port;
    @(posedge clk_i);
    ssr_raddr_i[p]  <= reg_num_t'(rows[r].reg_num);
    ssr_rvalid_i[p] <= 1'b1;
    for (n = 0; n < rows[r].count; n++) begin
      wait_rready(p, ok);
      if (!ok) begin
        break;
      end
      a = rows[r].base + addr_t'(n) * rows[r].stride;
      check_data($sformatf("ssr_rdata_o[%0d] word %0d", p, n), pattern(a), ssr_rdata_o[p]);
      repeat (next_delay(p, rows[r].max_delay)) @(posedge clk_i);
      @(posedge clk_i);
      ssr_rdone_i[p] <= 1'b1;
      @(posedge clk_i);
      ssr_rdone_i[p] <= 1'b0;
      // second start in mid stream has to be dropped
      if (rows[r].restart && n == rows[r].count / 2) begin
        cfg_read(cfg_at(rows[r].lane, CfgStart), word);
        check_flag("cfg_rdata_o busy in mid stream", 1'b1, word[0]);
        cfg_write(cfg_at(rows[r].lane, CfgStart), 32'd1);
      end
    end
    if (rows[r].restart && ok) begin
      cfg_read(cfg_at(rows[r].lane, CfgStart), word);
      check_flag("cfg_rdata_o busy after last beat", 1'b0, word[0]);
    end
    @(posedge clk_i);
    ssr_rvalid_i[p] <= 1'b0;
  endtask

  task automatic run_write(input int r);
    int n;
    bit ok;
    @(posedge clk_i);
    ssr_waddr_i  <= reg_num_t'(rows[r].reg_num);
    ssr_wvalid_i <= 1'b1;
    for (n = 0; n < rows[r].count; n++) begin
      wait_wready(ok);
      if (!ok) begin
        break;
      end
      repeat (next_delay(WritePort, rows[r].max_delay)) @(posedge clk_i);
      @(posedge clk_i);
      ssr_wdata_i <= write_word(r, n);
      ssr_wdone_i <= 1'b1;
      @(posedge clk_i);
      ssr_wdone_i <= 1'b0;
    end
    @(posedge clk_i);
    ssr_wvalid_i <= 1'b0;
  endtask

  // a register outside the map must never see ready
  task automatic watch_unmapped(input int r);
    int p;
    p = rows[r].port;
    @(posedge clk_i);
    ssr_raddr_i[p]  <= reg_num_t'(rows[r].reg_num);
    ssr_rvalid_i[p] <= 1'b1;
    for (int cyc = 0; cyc < WatchCycles; cyc++) begin
      @(negedge clk_i);
      check_flag($sformatf("ssr_rready_o[%0d] unmapped", p), 1'b0, ssr_rready_o[p]);
      if (ssr_rready_o[p]) begin
        break;
      end
    end
    @(posedge clk_i);
    ssr_rvalid_i[p] <= 1'b0;
  endtask

  task automatic run_row(input int r);
    if (r < 0) begin
      return;
    end
    if (!mapped(rows[r].reg_num)) begin
      watch_unmapped(r);
    end else if (rows[r].write) begin
      run_write(r);
    end else begin
      run_read(r);
    end
  endtask

  task automatic finish_row(input int r);
    bit    ok;
    int    lane;
    addr_t a;
    addr_t off;
    addr_t last;
    if (r < 0 || !mapped(rows[r].reg_num)) begin
      return;
    end
    lane = rows[r].lane;
    wait_idle(lane, ok);
    if (!ok) begin
      return;
    end
    if (rows[r].write) begin
      // stream words sit at their slots with untouched fill in between
      last = rows[r].base + addr_t'(rows[r].count) * rows[r].stride;
      for (a = rows[r].base; a < last; a = a + 32'd8) begin
        off = a - rows[r].base;
        if (off % rows[r].stride == 32'd0) begin
          check_data($sformatf("memory %h", a), write_word(r, int'(off / rows[r].stride)),
                     mem_q[lane][a[10:3]]);
        end else begin
          check_data($sformatf("memory %h", a), pattern(a), mem_q[lane][a[10:3]]);
        end
      end
    end else if (rows[r].restart) begin
      // a restarted lane would prefetch again
      @(posedge clk_i);
      ssr_rvalid_i[rows[r].port] <= 1'b1;
      repeat (16) begin
        @(negedge clk_i);
        check_flag("ssr_rready_o after stream end", 1'b0, ssr_rready_o[rows[r].port]);
      end
      @(posedge clk_i);
      ssr_rvalid_i[rows[r].port] <= 1'b0;
    end
  endtask

  task automatic report_test(input int num, input string name, input int errs_before);
    tests_run++;
    if (errors != errs_before) begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - errs_before);
    end else begin
      $display("test %0d %s: ok", num, name);
    end
  endtask

  initial begin
    int errs;
    int first;
    int second;
    // grp lane port reg base stride count write gnt% delay restart
    rows[0] = '{0, 0, 0, 0, 32'h100, 32'd8, 12, 1'b0, 100, 0, 1'b0};
    rows[1] = '{1, 1, WritePort, 1, 32'h200, 32'd16, 10, 1'b1, 60, 2, 1'b0};
    rows[2] = '{2, 0, 1, 0, 32'h040, 32'd24, 16, 1'b0, 50, 3, 1'b0};
    rows[3] = '{2, 1, 2, 1, 32'h300, 32'd8, 20, 1'b0, 40, 2, 1'b0};
    rows[4] = '{3, 0, 0, 7, 32'h0, 32'd8, 0, 1'b0, 100, 0, 1'b0};
    rows[5] = '{3, 1, 1, 1, 32'h080, 32'd8, 8, 1'b0, 70, 1, 1'b0};
    names[0] = "read stream lane 0";
    names[1] = "write stream lane 1";
    names[2] = "two read streams, random stalls";
    names[3] = "unmapped register";
    names[4] = "restart while busy";
    for (int l = 0; l < NumLanes; l++) begin
      gnt_pct[l] = 100;
    end
    for (int p = 0; p < 4; p++) begin
      core_rng[p] = Seed + 32'(p);
    end
    fill_memory();
    reset_i      <= 1'b1;
    ssr_raddr_i  <= '{default: '0};
    ssr_rvalid_i <= '{default: 1'b0};
    ssr_rdone_i  <= '{default: 1'b0};
    ssr_waddr_i  <= '0;
    ssr_wdata_i  <= '0;
    ssr_wvalid_i <= 1'b0;
    ssr_wdone_i  <= 1'b0;
    cfg_we_i     <= 1'b0;
    cfg_addr_i   <= '0;
    cfg_wdata_i  <= '0;
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    @(posedge clk_i);

    errs = errors;
    config_readback();
    report_test(1, "configuration readback", errs);

    for (int g = 0; g < NumGroups; g++) begin
      errs = errors;
      first = -1;
      second = -1;
      for (int r = 0; r < NumRows; r++) begin
        if (rows[r].grp == g) begin
          if (first < 0) begin
            first = r;
          end else begin
            second = r;
          end
        end
      end
      if (g == NumGroups - 1) begin
        // last test reuses row 0 with a mid stream start
        first = 0;
        rows[0].restart = 1'b1;
        rows[0].gnt_pct = 80;
        rows[0].max_delay = 1;
      end
      fill_memory();
      start_row(first);
      start_row(second);
      fork
        run_row(first);
        run_row(second);
      join
      finish_row(first);
      finish_row(second);
      report_test(g + 2, names[g], errs);
    end

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
